//--- hw/calc_defs.svh
`ifndef CALC_DEFS_SVH
`define CALC_DEFS_SVH

// Datapath width for operands, results and display
`define CALC_WIDTH 16

// Keypad digit width
`define CALC_DIGIT_W 4

// Largest digit the entry block accepts
`define CALC_MAX_DIGIT 9

// Operator code width (one bit per operator)
`define CALC_OP_W 3

// Decimal radix used while building operands
`define CALC_RADIX 10

`endif

//--- hw/calc_keys_pkg.sv
`default_nettype none

`include "calc_defs.svh"

// Keypad side encodings
package calc_keys_pkg;

    // One-hot operator key
    typedef enum logic [`CALC_OP_W-1:0] {
        OP_NONE = 3'b000,   // No operator latched
        OP_ADD  = 3'b001,   // Addition
        OP_SUB  = 3'b010,   // Subtraction
        OP_MUL  = 3'b100    // Multiplication
    } op_code_t;

    // True only for the three legal one-hot codes
    function automatic logic op_is_valid(input op_code_t op);
        logic ok;
        ok = (op == OP_ADD) || (op == OP_SUB) || (op == OP_MUL);
        return ok;
    endfunction

endpackage

`default_nettype wire

//--- hw/calc_exec_pkg.sv
`default_nettype none

// Execution side types
package calc_exec_pkg;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        IDLE      = 3'b000,   // Waiting for a request
        DISPATCH  = 3'b001,   // Start pulse to chosen unit
        WAIT_UNIT = 3'b010,   // Waiting for finish
        SHOW      = 3'b011    // Complete pulse
    } seq_state_t;

    // Which arithmetic unit owns the calculation
    typedef enum logic {
        UNIT_ADDSUB = 1'b0,   // Single cycle adder/subtractor
        UNIT_MUL    = 1'b1    // Iterative multiplier
    } unit_sel_t;

    // Multiply goes to the shift-add unit, everything else to the adder
    function automatic unit_sel_t unit_for_mul(input logic is_mul);
        unit_sel_t u;
        u = is_mul ? UNIT_MUL : UNIT_ADDSUB;
        return u;
    endfunction

endpackage

`default_nettype wire

//--- hw/operand_entry.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module operand_entry (
    input  logic                      clk,
    input  logic                      nRST,
    input  logic                      key_strobe,    // Digit key pressed
    input  logic [`CALC_DIGIT_W-1:0]  key_digit,
    input  logic                      op_strobe,     // Operator key pressed
    input  calc_keys_pkg::op_code_t   op_key,
    input  logic                      equal_strobe,  // Equal key pressed
    input  logic                      busy,          // Sequencer is working
    output logic                      req_strobe,    // One cycle request
    output logic [`CALC_WIDTH-1:0]    req_a,
    output logic [`CALC_WIDTH-1:0]    req_b,
    output calc_keys_pkg::op_code_t   req_op
);
    import calc_keys_pkg::*;

    localparam int W = `CALC_WIDTH;

    logic         second;          // High while building operand two
    op_code_t     op_r;            // Latched operator
    logic [W-1:0] acc_a;           // First operand accumulator
    logic [W-1:0] acc_b;           // Second operand accumulator
    logic [W-1:0] acc_sel;         // Accumulator being typed into
    logic [W-1:0] acc_next;        // acc_sel * 10 + digit
    logic         digit_ok;
    logic         op_ok;
    logic         equal_ok;

    // Keys count only while the sequencer is idle
    assign digit_ok = !busy && key_strobe && (key_digit <= `CALC_MAX_DIGIT);
    assign op_ok    = !busy && op_strobe && !second && op_is_valid(op_key);
    assign equal_ok = !busy && equal_strobe && second;

    assign acc_sel  = second ? acc_b : acc_a;
    // Wraps modulo 2^W
    assign acc_next = acc_sel * W'(`CALC_RADIX) + W'(key_digit);

    // Phase, operator and accumulators
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            second     <= 1'b0;
            op_r       <= OP_NONE;
            acc_a      <= '0;
            acc_b      <= '0;
            req_strobe <= 1'b0;
        end else begin
            req_strobe <= equal_ok;
            if (equal_ok) begin
                second <= 1'b0;     // Back to first operand
                op_r   <= OP_NONE;
                acc_a  <= '0;
                acc_b  <= '0;
            end else if (op_ok) begin
                second <= 1'b1;
                op_r   <= op_key;
            end else if (digit_ok) begin
                if (second) begin
                    acc_b <= acc_next;
                end else begin
                    acc_a <= acc_next;
                end
            end
        end
    end

    // Request payload, only read with req_strobe
    always_ff @(posedge clk) begin
        if (equal_ok) begin
            req_a  <= acc_a;
            req_b  <= acc_b;
            req_op <= op_r;
        end
    end

    // Entry returns to phase one after a request so strobes cannot repeat
    a_req_single: assert property (@(posedge clk) disable iff (!nRST)
        req_strobe |=> !req_strobe)
        else $error("req_strobe high on two cycles in a row");

endmodule

`default_nettype wire

//--- hw/add_sub_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module add_sub_unit #(
    parameter int WIDTH = `CALC_WIDTH
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,    // Operands valid this cycle only
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             sub,      // 1 selects a - b
    output logic [WIDTH-1:0] result,
    output logic             finish    // One cycle after start
);

    logic [WIDTH-1:0] sum_next;

    // Unsigned with wraparound
    assign sum_next = sub ? (a - b) : (a + b);

    // Result register
    always_ff @(posedge clk) begin
        if (start) begin
            result <= sum_next;
        end
    end

    // Finish strobe
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

endmodule

`default_nettype wire

//--- hw/shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module shift_add_multiplier #(
    parameter int WIDTH = `CALC_WIDTH
) (
    input  logic             clk,
    input  logic             nRST,
    input  logic             start,    // Operands valid this cycle only
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    output logic [WIDTH-1:0] result,   // Low WIDTH bits of a*b
    output logic             finish    // WIDTH cycles after start
);

    localparam int CNT_W = $clog2(WIDTH) + 1;

    logic [WIDTH-1:0] mcand;      // Multiplicand, shifted left each step
    logic [WIDTH-1:0] mplier;     // Multiplier, shifted right each step
    logic [WIDTH-1:0] acc;        // Partial product
    logic [WIDTH-1:0] addend;
    logic [CNT_W-1:0] count;      // Steps done so far
    logic             running;
    logic             last_step;

    assign addend    = mplier[0] ? mcand : '0;
    assign last_step = (count == CNT_W'(WIDTH - 1));
    assign result    = acc;

    // Datapath; bit 0 is consumed in the load cycle
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= b[0] ? a : '0;
            mcand  <= a << 1;
            mplier <= b >> 1;
        end else if (running) begin
            acc    <= acc + addend;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Step counter and finish
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            running <= 1'b0;
            count   <= '0;
            finish  <= 1'b0;
        end else begin
            if (start) begin
                count   <= CNT_W'(1);
                running <= (WIDTH > 1);
                finish  <= (WIDTH == 1);    // Single bit needs no extra steps
            end else if (running) begin
                count <= count + 1'b1;
                if (last_step) begin
                    running <= 1'b0;
                    finish  <= 1'b1;
                end else begin
                    finish  <= 1'b0;
                end
            end else begin
                finish <= 1'b0;
            end
        end
    end

    // Finish comes WIDTH cycles after its start
    a_finish_after_start: assert property (@(posedge clk) disable iff (!nRST)
        finish |-> $past(start, WIDTH))
        else $error("multiplier finish without a start");

    // Sequencer must not restart a product in flight
    a_no_start_busy: assert property (@(posedge clk) disable iff (!nRST)
        start |-> !running)
        else $error("multiplier started while busy");

endmodule

`default_nettype wire

//--- hw/calc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module calc_sequencer (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     req_strobe,   // From entry block
    input  logic [`CALC_WIDTH-1:0]   req_a,
    input  logic [`CALC_WIDTH-1:0]   req_b,
    input  calc_keys_pkg::op_code_t  req_op,
    output logic                     busy,         // Drop keys while high
    output logic                     start_add,
    output logic                     start_mul,
    output logic                     sub,
    output logic [`CALC_WIDTH-1:0]   unit_a,
    output logic [`CALC_WIDTH-1:0]   unit_b,
    input  logic                     finish_add,
    input  logic                     finish_mul,
    input  logic [`CALC_WIDTH-1:0]   sum_out,
    input  logic [`CALC_WIDTH-1:0]   prod_out,
    output logic                     complete,     // One cycle in SHOW
    output logic [`CALC_WIDTH-1:0]   display_output
);
    import calc_keys_pkg::*;
    import calc_exec_pkg::*;

    seq_state_t             state, state_next;
    unit_sel_t              unit_r;        // Unit chosen for this request
    logic                   unit_done;
    logic [`CALC_WIDTH-1:0] unit_result;

    // Read back only the unit that was started
    assign unit_done   = (unit_r == UNIT_MUL) ? finish_mul : finish_add;
    assign unit_result = (unit_r == UNIT_MUL) ? prod_out : sum_out;

    assign busy      = (state != IDLE);
    assign start_add = (state == DISPATCH) && (unit_r == UNIT_ADDSUB);
    assign start_mul = (state == DISPATCH) && (unit_r == UNIT_MUL);
    assign complete  = (state == SHOW);

    always_comb begin
        state_next = state;
        case (state)
            IDLE:      if (req_strobe) state_next = DISPATCH;
            DISPATCH:  state_next = WAIT_UNIT;
            WAIT_UNIT: if (unit_done) state_next = SHOW;
            SHOW:      state_next = IDLE;    // Single calculation per request
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= IDLE;
            unit_r         <= UNIT_ADDSUB;
            display_output <= '0;
        end else begin
            state <= state_next;
            if (state == IDLE && req_strobe) begin
                unit_r <= unit_for_mul(req_op == OP_MUL);
            end
            if (state == WAIT_UNIT && unit_done) begin
                display_output <= unit_result;   // Valid with complete
            end
        end
    end

    // Operands held until the unit registers them at start
    always_ff @(posedge clk) begin
        if (state == IDLE && req_strobe) begin
            unit_a <= req_a;
            unit_b <= req_b;
            sub    <= (req_op == OP_SUB);
        end
    end

    a_one_start: assert property (@(posedge clk) disable iff (!nRST)
        !(start_add && start_mul))
        else $error("both arithmetic units started");

endmodule

`default_nettype wire

//--- hw/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module calc_top (
    input  logic                     clk,
    input  logic                     nRST,
    input  logic                     key_strobe,
    input  logic [`CALC_DIGIT_W-1:0] key_digit,
    input  logic                     op_strobe,
    input  calc_keys_pkg::op_code_t  op_key,
    input  logic                     equal_strobe,
    output logic                     complete,
    output logic [`CALC_WIDTH-1:0]   display_output
);
    import calc_keys_pkg::*;

    // Entry to sequencer
    logic                   req_strobe;
    logic [`CALC_WIDTH-1:0] req_a;
    logic [`CALC_WIDTH-1:0] req_b;
    op_code_t               req_op;
    logic                   busy;

    // Sequencer to units
    logic                   start_add;
    logic                   start_mul;
    logic                   sub;
    logic [`CALC_WIDTH-1:0] unit_a;
    logic [`CALC_WIDTH-1:0] unit_b;
    logic                   finish_add;
    logic                   finish_mul;
    logic [`CALC_WIDTH-1:0] sum_out;
    logic [`CALC_WIDTH-1:0] prod_out;

    operand_entry u_entry (
        .clk          (clk),
        .nRST         (nRST),
        .key_strobe   (key_strobe),
        .key_digit    (key_digit),
        .op_strobe    (op_strobe),
        .op_key       (op_key),
        .equal_strobe (equal_strobe),
        .busy         (busy),
        .req_strobe   (req_strobe),
        .req_a        (req_a),
        .req_b        (req_b),
        .req_op       (req_op)
    );

    calc_sequencer u_seq (
        .clk            (clk),
        .nRST           (nRST),
        .req_strobe     (req_strobe),
        .req_a          (req_a),
        .req_b          (req_b),
        .req_op         (req_op),
        .busy           (busy),
        .start_add      (start_add),
        .start_mul      (start_mul),
        .sub            (sub),
        .unit_a         (unit_a),
        .unit_b         (unit_b),
        .finish_add     (finish_add),
        .finish_mul     (finish_mul),
        .sum_out        (sum_out),
        .prod_out       (prod_out),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit #(.WIDTH(`CALC_WIDTH)) u_addsub (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_add),
        .a      (unit_a),
        .b      (unit_b),
        .sub    (sub),
        .result (sum_out),
        .finish (finish_add)
    );

    shift_add_multiplier #(.WIDTH(`CALC_WIDTH)) u_mul (
        .clk    (clk),
        .nRST   (nRST),
        .start  (start_mul),
        .a      (unit_a),
        .b      (unit_b),
        .result (prod_out),
        .finish (finish_mul)
    );

endmodule

`default_nettype wire

//--- tests/calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "calc_defs.svh"

module calc_tb;
    import calc_keys_pkg::*;
    import calc_exec_pkg::*;

    localparam int W           = `CALC_WIDTH;
    localparam int WAIT_LIMIT  = 4 * `CALC_WIDTH;   // Per record wait for complete
    localparam int NONE_WINDOW = `CALC_WIDTH + 8;   // Quiet time when no result is due

    logic                     clk;
    logic                     nRST;
    logic                     key_strobe;
    logic [`CALC_DIGIT_W-1:0] key_digit;
    logic                     op_strobe;
    op_code_t                 op_key;
    logic                     equal_strobe;
    logic                     complete;
    logic [W-1:0]             display_output;

    string        name_q[$];                 // Records from the stim file
    string        keys_q[$];
    int           exp_q[$];                  // -1 means no result expected
    int           error_count   = 0;
    int           complete_count = 0;
    int           cycle_count   = 0;
    int           cycle_limit   = 100;       // Raised once the records are known
    logic [W-1:0] captured_result = '0;      // display_output seen with complete
    logic [W-1:0] last_display  = '0;        // Model of what the display shows

    calc_top u_dut (
        .clk            (clk),
        .nRST           (nRST),
        .key_strobe     (key_strobe),
        .key_digit      (key_digit),
        .op_strobe      (op_strobe),
        .op_key         (op_key),
        .equal_strobe   (equal_strobe),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;               // 8 ns period
    end

    // Mid cycle sampling of the complete strobe
    always @(negedge clk) begin
        if (nRST && complete) begin
            complete_count++;
            captured_result = display_output;
        end
    end

    // Run length guard
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Errors: %0d plus the timeout", error_count);
            $display("Done: errors found");
            $finish;
        end
    end

    // Inputs change 1 ns after the rising edge
    task automatic step_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string test_name, input logic [W-1:0] expected,
                               input logic [W-1:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("** Error: %s expected %0d actual %0d", test_name, expected, actual);
        end
    endtask

    // One key, held for a single sampling edge
    task automatic press_key(input logic [7:0] ch);
        if (ch >= "0" && ch <= "9") begin
            key_strobe = 1'b1;
            key_digit  = ch[3:0];
        end else if (ch >= "a" && ch <= "f") begin
            key_strobe = 1'b1;
            key_digit  = ch[3:0] + 4'd9;     // Codes 10 to 15
        end else if (ch == "+") begin
            op_strobe = 1'b1;
            op_key    = OP_ADD;
        end else if (ch == "-") begin
            op_strobe = 1'b1;
            op_key    = OP_SUB;
        end else if (ch == "*") begin
            op_strobe = 1'b1;
            op_key    = OP_MUL;
        end else if (ch == "?") begin
            op_strobe = 1'b1;
            op_key    = op_code_t'(3'b011);  // Two bits set
        end else if (ch == "=") begin
            equal_strobe = 1'b1;
        end else begin
            error_count++;
            $display("Unknown key character '%c' in the stim file", ch);
        end
        step_cycle();
        key_strobe   = 1'b0;
        op_strobe    = 1'b0;
        equal_strobe = 1'b0;
    endtask

    task automatic load_stim();
        int    fd;
        int    n;
        string line;
        string f_name;
        string f_keys;
        string f_exp;
        fd = $fopen("tests/calc_stim.txt", "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open tests/calc_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %s %s", f_name, f_keys, f_exp);
                if (n == 3) begin
                    name_q.push_back(f_name);
                    keys_q.push_back(f_keys);
                    exp_q.push_back((f_exp == "none") ? -1 : f_exp.atoi());
                end
            end
        end
        $fclose(fd);
    endtask

    // Keys before '=' get random gaps, keys after it go in back to back while busy
    task automatic run_record(input string name, input string keys, input int expected);
        int           i;
        int           start_count;
        int           waited;
        logic         after_equal;
        logic [7:0]   ch;
        logic [W-1:0] exp_val;
        unit_sel_t    unit;
        start_count = complete_count;
        after_equal = 1'b0;
        unit        = UNIT_ADDSUB;
        exp_val     = W'(expected);
        for (i = 0; i < keys.len(); i++) begin
            ch = keys.getc(i);
            if (after_equal) begin
                press_key(ch);
            end else begin
                repeat ($urandom_range(3, 0)) step_cycle();
                if (ch == "*") unit = UNIT_MUL;
                if (ch == "=") begin
                    check_value({name, " hold"}, last_display, display_output);
                    press_key(ch);
                    after_equal = 1'b1;
                    repeat (2) step_cycle();     // Sequencer is busy from here
                end else begin
                    press_key(ch);
                end
            end
        end
        $display("Record %s keys %s unit %s", name, keys, unit.name());
        // Old result stays on the display while the unit works
        if (complete_count == start_count)
            check_value({name, " busy hold"}, last_display, display_output);
        if (expected >= 0) begin
            waited = 0;
            while (complete_count == start_count && waited < WAIT_LIMIT) begin
                step_cycle();
                waited++;
            end
            if (complete_count == start_count) begin
                error_count++;
                $display("%s: no complete within %0d cycles", name, WAIT_LIMIT);
            end else begin
                check_value(name, exp_val, captured_result);
                last_display = exp_val;
            end
            repeat (3) step_cycle();
            if (complete_count > start_count + 1) begin
                error_count++;
                $display("%s: more than one complete for one calculation", name);
            end
        end else begin
            repeat (NONE_WINDOW) step_cycle();
            if (complete_count != start_count) begin
                error_count++;
                $display("%s: a complete arrived although no result was due", name);
            end
        end
    endtask

    initial begin
        int r;
        nRST         = 1'b0;
        key_strobe   = 1'b0;
        key_digit    = '0;
        op_strobe    = 1'b0;
        op_key       = OP_NONE;
        equal_strobe = 1'b0;
        void'($urandom(32'h63c8_c0ef));      // Seeds the generator
        load_stim();
        cycle_limit  = 40 * name_q.size() + 100;
        repeat (8) @(posedge clk);
        #1;
        nRST = 1'b1;
        repeat (2) step_cycle();
        for (r = 0; r < name_q.size(); r++) begin
            run_record(name_q[r], keys_q[r], exp_q[r]);
        end
        $display("Checked %0d records, %0d errors", name_q.size(), error_count);
        if (error_count == 0 && name_q.size() > 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/calc_stim.txt
# name  keys  expected (decimal result or none)
# keys: 0-9 digits, a-f digit codes 10-15, + - * operators, ? bad operator, = equal
# keys after = are sent back to back while the multiplier is busy
add_basic     123+456=     579
sub_basic     900-25=      875
sub_wrap      5-7=         65534
mul_basic     12*34=       408
mul_trunc     300*300=     24464
entry_wrap    99999+0=     34463
digit_high    1a2+3c=      15
eq_early      42=          none
eq_early_cont +8=          50
op_twice      7+5-3=       60
op_invalid    6?4*2=       128
busy_keys     250*4=77+9   1000
after_busy    +2=          2
back_a        3*3=         9
back_b        100-1=       99
mul_zero      0*65535=     0
mul_big       65535*65535= 1
no_digits     -5=          65531
add_wrap      65535+2=     1
empty_eq      =            none
mul_after     9*9=         81

//--- sources.f
+incdir+hw
hw/calc_keys_pkg.sv
hw/calc_exec_pkg.sv
hw/operand_entry.sv
hw/add_sub_unit.sv
hw/shift_add_multiplier.sv
hw/calc_sequencer.sv
hw/calc_top.sv
tests/calc_tb.sv

//--- Makefile
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= calc_tb
FILELIST ?= sources.f
BUILD    ?= obj_dir
LOG      ?= sim.log
FAIL_MSG  = Done: errors found

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@./$(BUILD)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
